// File: hw/ex_macros.svh
// width definitions shared by the EX stage RTL and testbench
// the ALU encodings assume RV32, so EX_XLEN must stay at 32
// EX_SHAMT_W has to be log2 of EX_XLEN
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data and address width
`define EX_XLEN 32

// register file address width
`define EX_RADDR_W 5

// shift amount taken from operand b
`define EX_SHAMT_W 5

// load/store access size code
`define EX_LSU_TYPE_W 2

`endif

// File: hw/ex_pkg.sv
// operator encodings and payload structs of the EX stage
// all payloads are packed so one generic stage register carries them
// ALU_ADD must stay at code zero because a reset register decodes as ADD
`include "ex_macros.svh"

package ex_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,  // branch compares from here on
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  typedef enum logic [`EX_LSU_TYPE_W-1:0] {
    LSU_WORD = 0,
    LSU_HALF = 1,
    LSU_BYTE = 2
  } lsu_type_e;

  typedef enum logic [1:0] {
    WB_INSTR_LOAD  = 0,
    WB_INSTR_STORE = 1,
    WB_INSTR_OTHER = 2
  } wb_instr_type_e;

  typedef struct packed {
    alu_op_e              op;
    logic [`EX_XLEN-1:0]  operand_a;
    logic [`EX_XLEN-1:0]  operand_b;
  } alu_req_t;

  // branch target operands, normally pc and immediate
  typedef struct packed {
    logic [`EX_XLEN-1:0]  operand_a;
    logic [`EX_XLEN-1:0]  operand_b;
  } bt_req_t;

  typedef struct packed {
    alu_req_t  alu;
    bt_req_t   bt;
  } ex_op_t;

  typedef struct packed {
    logic                 req;       // strobe, valid this cycle
    logic                 we;
    lsu_type_e            lsu_type;
    logic [`EX_XLEN-1:0]  wdata;
    logic                 sign_ext;
  } lsu_req_t;

  typedef struct packed {
    logic                    en_wb;  // strobe, valid this cycle
    wb_instr_type_e          instr_type;
    logic [`EX_XLEN-1:0]     pc;
    logic                    is_compressed;
    logic                    perf_count;
    logic [`EX_RADDR_W-1:0]  rf_waddr;
    logic [`EX_XLEN-1:0]     rf_wdata;
    logic                    rf_we;  // strobe
    logic                    dummy_instr;
  } wb_info_t;

endpackage

// File: hw/ex_pipe_reg.sv
// one-cycle stage register for any packed payload
// resets asynchronously to all zeros, no enable and no stall

`timescale 1ns/1ps

module ex_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  payload_t  d_i,
  output payload_t  q_o
);

  // every field clears, so strobes inside the payload read as idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q_o <= '0;
    end else begin
      q_o <= d_i;  // new item every clock
    end
  end

endmodule

// File: hw/ex_alu.sv
// single-cycle RV32 integer ALU, purely combinational
// comparisons run the adder in subtract mode, so adder_result_o is a-b for them
// shifts use only the low EX_SHAMT_W bits of operand b

`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu (
  input  ex_pkg::alu_req_t     req_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic [`EX_XLEN-1:0]  adder_result_o,  // also the LSU address
  output logic                 cmp_result_o
);
  import ex_pkg::*;

  logic                 adder_negate;
  logic [`EX_XLEN-1:0]  adder_op_b;
  logic [`EX_XLEN:0]    adder_cin;
  logic [`EX_XLEN:0]    adder_sum;     // top bit is the carry out

  logic                 is_equal;
  logic                 lt_signed;
  logic                 lt_unsigned;

  logic [`EX_SHAMT_W-1:0] shamt;
  logic                 shift_left;
  logic                 shift_arith;
  logic [`EX_XLEN-1:0]  operand_a_rev;
  logic [`EX_XLEN-1:0]  shift_src;
  logic [`EX_XLEN:0]    shift_ext;
  logic [`EX_XLEN-1:0]  shift_right;
  logic [`EX_XLEN-1:0]  shift_right_rev;
  logic [`EX_XLEN-1:0]  shift_result;

  //////////////////////////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////////////////////////

  // only ADD and the non-arithmetic ops keep b as is
  always_comb begin
    case (req_i.op)
      ALU_ADD, ALU_XOR, ALU_OR, ALU_AND,
      ALU_SLL, ALU_SRL, ALU_SRA: adder_negate = 1'b0;
      default:                   adder_negate = 1'b1;
    endcase
  end

  assign adder_op_b     = adder_negate ? ~req_i.operand_b : req_i.operand_b;
  assign adder_cin      = {{`EX_XLEN{1'b0}}, adder_negate};  // +1 completes two's complement
  assign adder_sum      = {1'b0, req_i.operand_a} + {1'b0, adder_op_b} + adder_cin;
  assign adder_result_o = adder_sum[`EX_XLEN-1:0];

  //////////////////////////////////////////////////////////////////////
  // comparator
  //////////////////////////////////////////////////////////////////////

  assign is_equal    = ~|(req_i.operand_a ^ req_i.operand_b);
  assign lt_unsigned = ~adder_sum[`EX_XLEN];  // borrow out of a-b

  // differing signs decide directly, otherwise the difference cannot overflow
  assign lt_signed = (req_i.operand_a[`EX_XLEN-1] != req_i.operand_b[`EX_XLEN-1]) ?
                     req_i.operand_a[`EX_XLEN-1] : adder_sum[`EX_XLEN-1];

  always_comb begin
    case (req_i.op)
      ALU_EQ:            cmp_result_o = is_equal;
      ALU_NE:            cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:   cmp_result_o = lt_signed;
      ALU_GE:            cmp_result_o = ~lt_signed;
      ALU_LTU, ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_GEU:           cmp_result_o = ~lt_unsigned;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // shifter
  //////////////////////////////////////////////////////////////////////

  // one right shifter, left shifts go through bit reversal
  assign shamt         = req_i.operand_b[`EX_SHAMT_W-1:0];
  assign shift_left    = (req_i.op == ALU_SLL);
  assign shift_arith   = (req_i.op == ALU_SRA);
  assign operand_a_rev = {<<{req_i.operand_a}};
  assign shift_src     = shift_left ? operand_a_rev : req_i.operand_a;

  // extra top bit carries the fill value
  assign shift_ext       = $signed({shift_arith & shift_src[`EX_XLEN-1], shift_src}) >>> shamt;
  assign shift_right     = shift_ext[`EX_XLEN-1:0];
  assign shift_right_rev = {<<{shift_right}};
  assign shift_result    = shift_left ? shift_right_rev : shift_right;

  //////////////////////////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ALU_ADD, ALU_SUB:          result_o = adder_result_o;
      ALU_XOR:                   result_o = req_i.operand_a ^ req_i.operand_b;
      ALU_OR:                    result_o = req_i.operand_a | req_i.operand_b;
      ALU_AND:                   result_o = req_i.operand_a & req_i.operand_b;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      default:                   result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};  // slt, branches
    endcase
  end

endmodule

// File: hw/ex_block.sv
// execute stage of a small in-order RV32 core, one item per clock
// there is no stall and no back-pressure so ID must hold or insert bubbles itself
// every output follows the inputs by exactly one cycle and is zero after reset

`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_block #(
  parameter bit BranchTargetALU = 1'b1  // dedicated adder for the branch target
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // from ID, sampled every clock
  input  ex_pkg::ex_op_t       ex_op_i,
  input  ex_pkg::lsu_req_t     lsu_req_i,
  input  ex_pkg::wb_info_t     wb_info_i,

  // results
  output logic [`EX_XLEN-1:0]  result_o,
  output logic [`EX_XLEN-1:0]  adder_result_o,    // to LSU
  output logic [`EX_XLEN-1:0]  branch_target_o,   // to IF
  output logic                 branch_decision_o, // to ID

  // EX/MA forwarding
  output ex_pkg::lsu_req_t     lsu_req_o,
  output ex_pkg::wb_info_t     wb_info_o
);
  import ex_pkg::*;

  ex_op_t               ex_op_q;
  logic [`EX_XLEN-1:0]  alu_result;
  logic [`EX_XLEN-1:0]  alu_adder_result;
  logic                 alu_cmp_result;

  //////////////////////////////////////////////////////////////////////
  // stage registers
  //////////////////////////////////////////////////////////////////////

  ex_pipe_reg #(
    .payload_t(ex_op_t)
  ) id_ex_reg_i (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (ex_op_i),
    .q_o   (ex_op_q)
  );

  // LSU request and write-back info only ride along to MA
  ex_pipe_reg #(
    .payload_t(lsu_req_t)
  ) lsu_reg_i (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (lsu_req_i),
    .q_o   (lsu_req_o)
  );

  ex_pipe_reg #(
    .payload_t(wb_info_t)
  ) wb_reg_i (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (wb_info_i),
    .q_o   (wb_info_o)
  );

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .req_i         (ex_op_q.alu),
    .result_o      (alu_result),
    .adder_result_o(alu_adder_result),
    .cmp_result_o  (alu_cmp_result)
  );

  assign result_o          = alu_result;
  assign adder_result_o    = alu_adder_result;
  assign branch_decision_o = alu_cmp_result;

  //////////////////////////////////////////////////////////////////////
  // branch target
  //////////////////////////////////////////////////////////////////////

  if (BranchTargetALU) begin : g_bt_alu
    // wraps at EX_XLEN bits, carry dropped
    assign branch_target_o = ex_op_q.bt.operand_a + ex_op_q.bt.operand_b;
  end else begin : g_no_bt_alu
    // ID must then put pc and offset on the ALU operands
    assign branch_target_o = alu_adder_result;
  end

endmodule

// File: bench/ex_block_sva.sv
// concurrent checks bound to ex_block
// the branch target check holds only with BranchTargetALU set

`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_block_sva (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ex_pkg::ex_op_t       ex_op_i,
  input  ex_pkg::lsu_req_t     lsu_req_i,
  input  ex_pkg::wb_info_t     wb_info_i,
  input  logic [`EX_XLEN-1:0]  branch_target_o,
  input  ex_pkg::lsu_req_t     lsu_req_o,
  input  ex_pkg::wb_info_t     wb_info_o
);

  logic [`EX_XLEN-1:0] bt_sum;  // wrapped target of the current inputs

  assign bt_sum = ex_op_i.bt.operand_a + ex_op_i.bt.operand_b;

  // from the second edge after release the registers carry real inputs
  lsu_forward_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> lsu_req_o == $past(lsu_req_i))
    else $error("lsu_req_o does not follow lsu_req_i by one cycle");

  wb_forward_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> wb_info_o == $past(wb_info_i))
    else $error("wb_info_o does not follow wb_info_i by one cycle");

  strobes_idle_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !lsu_req_o.req && !wb_info_o.en_wb && !wb_info_o.rf_we)
    else $error("strobe set in the first cycle after reset");

  branch_target_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> branch_target_o == $past(bt_sum))
    else $error("branch_target_o is not the previous bt sum");

endmodule

// File: bench/ex_block_tb.sv
// directed testbench for ex_block with the default BranchTargetALU
// inputs change on falling edges, outputs are checked at the next falling edge
// the run stops at the first error

`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_block_tb;
  import ex_pkg::*;

  localparam time half_period  = 2;
  localparam int  reset_cycles = 16;
  localparam int  reset_limit  = 64;  // cycles before release counts as lost

  typedef struct packed {
    ex_op_t   op;
    lsu_req_t lsu;
    wb_info_t wb;
  } stim_t;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  ex_op_t              ex_op;
  lsu_req_t            lsu_req;
  wb_info_t            wb_info;
  logic [`EX_XLEN-1:0] result;
  logic [`EX_XLEN-1:0] adder_result;
  logic [`EX_XLEN-1:0] branch_target;
  logic                branch_decision;
  lsu_req_t            lsu_req_q;
  wb_info_t            wb_info_q;
  int                  seed = 85;
  int                  errors = 0;
  logic [`EX_XLEN-1:0] edge_vals [6] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000,
                                         32'h0000_0001, 32'h7FFF_FFFF, 32'h0000_0025};

  ex_block dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ex_op_i          (ex_op),
    .lsu_req_i        (lsu_req),
    .wb_info_i        (wb_info),
    .result_o         (result),
    .adder_result_o   (adder_result),
    .branch_target_o  (branch_target),
    .branch_decision_o(branch_decision),
    .lsu_req_o        (lsu_req_q),
    .wb_info_o        (wb_info_q)
  );

  bind ex_block ex_block_sva sva_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ex_op_i        (ex_op_i),
    .lsu_req_i      (lsu_req_i),
    .wb_info_i      (wb_info_i),
    .branch_target_o(branch_target_o),
    .lsu_req_o      (lsu_req_o),
    .wb_info_o      (wb_info_o)
  );

  always #half_period clk_i = ~clk_i;

  initial begin
    rst_ni = 1'b0;
    repeat (reset_cycles) @(negedge clk_i);
    rst_ni <= 1'b1;  // after the main process has looked at this edge
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic compare_model(alu_op_e op, logic [`EX_XLEN-1:0] a, b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return $signed(a) < $signed(b);
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] golden_result(alu_op_e op, logic [`EX_XLEN-1:0] a, b);
    logic [`EX_SHAMT_W-1:0] sh;
    sh = b[`EX_SHAMT_W-1:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_XOR: return a ^ b;
      ALU_OR:  return a | b;
      ALU_AND: return a & b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      ALU_SRA: return $signed(a) >>> sh;
      default: return {{(`EX_XLEN-1){1'b0}}, compare_model(op, a, b)};  // slt and branches
    endcase
  endfunction

  // subtract mode for SUB and every comparison
  function automatic logic [`EX_XLEN-1:0] adder_model(alu_op_e op, logic [`EX_XLEN-1:0] a, b);
    return (op == ALU_SUB || op >= ALU_SLT) ? a - b : a + b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // helpers and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("FAIL: see errors above");
    $fatal(1, why);
  endtask

  task automatic wait_cycles(input int n);
    time deadline;
    int  seen;
    deadline = $time + time'(n + 1) * 2 * half_period;
    seen = 0;
    while (seen < n) begin
      @(negedge clk_i);
      seen++;
      if ($time > deadline) abort_run("falling clock edge did not arrive in time");
    end
  endtask

  task automatic compare_word(input string name, input logic [`EX_XLEN-1:0] act, expected);
    if (act !== expected) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, act, expected);
      errors++;
      abort_run("stopping at the first wrong value");
    end
  endtask

  task automatic compare_bit(input string name, input logic act, expected);
    if (act !== expected) begin
      $display("MISMATCH at %0d ns: %s is %b, expected %b", $time, name, act, expected);
      errors++;
      abort_run("stopping at the first wrong value");
    end
  endtask

  task automatic compare_lsu(input string name, input lsu_req_t act, expected);
    if (act !== expected) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, act, expected);
      errors++;
      abort_run("stopping at the first wrong value");
    end
  endtask

  task automatic compare_wb(input string name, input wb_info_t act, expected);
    if (act !== expected) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, act, expected);
      errors++;
      abort_run("stopping at the first wrong value");
    end
  endtask

  function automatic stim_t random_stimulus(alu_op_e op, logic [`EX_XLEN-1:0] a, b);
    stim_t s;
    s.op.alu.op           = op;
    s.op.alu.operand_a    = a;
    s.op.alu.operand_b    = b;
    s.op.bt.operand_a     = $random(seed);
    s.op.bt.operand_b     = $random(seed);
    s.lsu.req             = 1'($random(seed));
    s.lsu.we              = 1'($random(seed));
    s.lsu.lsu_type        = lsu_type_e'(2'($unsigned($random(seed)) % 3));
    s.lsu.wdata           = $random(seed);
    s.lsu.sign_ext        = 1'($random(seed));
    s.wb.en_wb            = 1'($random(seed));
    s.wb.instr_type       = wb_instr_type_e'(2'($unsigned($random(seed)) % 3));
    s.wb.pc               = $random(seed);
    s.wb.is_compressed    = 1'($random(seed));
    s.wb.perf_count       = 1'($random(seed));
    s.wb.rf_waddr         = `EX_RADDR_W'($random(seed));
    s.wb.rf_wdata         = $random(seed);
    s.wb.rf_we            = 1'($random(seed));
    s.wb.dummy_instr      = 1'($random(seed));
    return s;
  endfunction

  task automatic drive_inputs(input stim_t s);
    ex_op   = s.op;
    lsu_req = s.lsu;
    wb_info = s.wb;
  endtask

  task automatic check_outputs(input stim_t s);
    alu_op_e             op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    op = s.op.alu.op;
    a  = s.op.alu.operand_a;
    b  = s.op.alu.operand_b;
    compare_word("result_o", result, golden_result(op, a, b));
    compare_word("adder_result_o", adder_result, adder_model(op, a, b));
    compare_word("branch_target_o", branch_target, s.op.bt.operand_a + s.op.bt.operand_b);
    if (op >= ALU_SLT) compare_bit("branch_decision_o", branch_decision, compare_model(op, a, b));
    compare_lsu("lsu_req_o", lsu_req_q, s.lsu);
    compare_wb("wb_info_o", wb_info_q, s.wb);
  endtask

  task automatic check_zero_outputs();
    compare_word("result_o", result, '0);
    compare_word("adder_result_o", adder_result, '0);
    compare_word("branch_target_o", branch_target, '0);
    compare_bit("branch_decision_o", branch_decision, 1'b0);
    compare_lsu("lsu_req_o", lsu_req_q, '0);
    compare_wb("wb_info_o", wb_info_q, '0);
  endtask

  task automatic apply_and_check(input alu_op_e op, input logic [`EX_XLEN-1:0] a, b);
    stim_t s;
    s = random_stimulus(op, a, b);
    drive_inputs(s);
    wait_cycles(1);
    check_outputs(s);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  // live inputs during the first half of reset, idle ones before release
  task automatic verify_reset_state();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      if (rst_ni !== 1'b1) begin
        check_zero_outputs();
        if (cycles < reset_cycles / 2) drive_inputs(random_stimulus(ALU_SUB, $random(seed), 1));
        else drive_inputs('0);
      end
      cycles++;
      if (cycles > reset_limit) abort_run("reset was never released");
    end while (rst_ni !== 1'b1);
    check_zero_outputs();  // first cycle after release
  endtask

  task automatic arith_logic_ops();
    alu_op_e ops [5];
    ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
    foreach (ops[i]) begin
      for (int n = 0; n < 20; n++) apply_and_check(ops[i], $random(seed), $random(seed));
    end
  endtask

  task automatic shift_and_slt_ops();
    alu_op_e ops [5];
    ops = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
    foreach (ops[i]) begin
      foreach (edge_vals[j]) begin
        foreach (edge_vals[k]) apply_and_check(ops[i], edge_vals[j], edge_vals[k]);
      end
      for (int n = 0; n < 10; n++) apply_and_check(ops[i], $random(seed), $random(seed));
    end
  endtask

  task automatic branch_compares();
    alu_op_e             ops [6];
    logic [`EX_XLEN-1:0] a;
    ops = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    foreach (ops[i]) begin
      foreach (edge_vals[j]) begin
        foreach (edge_vals[k]) apply_and_check(ops[i], edge_vals[j], edge_vals[k]);
      end
      for (int n = 0; n < 10; n++) begin
        a = $random(seed);
        apply_and_check(ops[i], a, a);
        apply_and_check(ops[i], a, $random(seed));
      end
    end
  endtask

  // a new item at every falling edge, no idle cycle in between
  task automatic stream_back_to_back();
    logic [3:0] code;
    stim_t      s;
    for (int n = 0; n < 50; n++) begin
      code = 4'($random(seed));
      s = random_stimulus(alu_op_e'(code), $random(seed), $random(seed));
      drive_inputs(s);
      wait_cycles(1);
      check_outputs(s);
    end
  endtask

  initial begin
    ex_op   = '0;
    lsu_req = '0;
    wb_info = '0;
    verify_reset_state();
    arith_logic_ops();
    shift_and_slt_ops();
    branch_compares();
    stream_back_to_back();
    if (errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "checks failed");
    end
  end

endmodule

// File: ex_block.f
+incdir+hw
hw/ex_pkg.sv
hw/ex_pipe_reg.sv
hw/ex_alu.sv
hw/ex_block.sv
bench/ex_block_sva.sv
bench/ex_block_tb.sv

// File: run.sh
#!/bin/sh
# builds the ex_block testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module ex_block_tb -f ex_block.f -o ex_block_sim

# the log decides the result, so a stopped simulation still reaches the search
./obj_dir/ex_block_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
  exit 0
fi
exit 1
